//--- hw/alu.sv
`timescale 1ns/10ps

module alu
(
	input logic [datapathPkg::wordWidth-1:0] a,
	input logic [datapathPkg::wordWidth-1:0] b,
	input isaPkg::aluOpT aluOp,
	input logic carryIn,
	output logic [datapathPkg::wordWidth-1:0] result,
	output logic [datapathPkg::psrWidth-1:0] flagsNext,
	output logic [datapathPkg::psrWidth-1:0] flagsUpdate
);
	import isaPkg::*;
	import datapathPkg::*;

	localparam int msb = wordWidth - 1;

	logic addCarry;
	logic [wordWidth:0] sumWide;
	logic [wordWidth-1:0] sum;
	logic [wordWidth-1:0] difference;
	logic [3:0] shiftAmount;
	logic addOverflow;
	logic subOverflow;

	////////////////////////////////////////////////////////////////////////////
	// Shared adder and subtractor
	////////////////////////////////////////////////////////////////////////////

	// Stored carry only enters for add with carry
	assign addCarry = (aluOp == aluAddC) ? carryIn : 1'b0;
	assign sumWide = {1'b0, a} + {1'b0, b} + {{wordWidth{1'b0}}, addCarry};
	assign sum = sumWide[msb:0];
	assign difference = a - b;

	// Two's complement overflow
	assign addOverflow = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
	assign subOverflow = (a[msb] != b[msb]) && (difference[msb] != a[msb]);

	assign shiftAmount = b[3:0];

	////////////////////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		result = b;
		flagsNext = '0;
		flagsUpdate = '0;

		case (aluOp)
			aluAdd:
			begin
				result = sum;
				flagsNext[flagBit] = addOverflow;
				flagsUpdate[flagBit] = 1'b1;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluAddU, aluAddC:
			begin
				result = sum;
				flagsNext[carryBit] = sumWide[wordWidth];
				flagsUpdate[carryBit] = 1'b1;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluSub:
			begin
				result = difference;
				flagsNext[flagBit] = subOverflow;
				flagsUpdate[flagBit] = 1'b1;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluCmp:
			begin
				// Result is never written back
				result = difference;
				flagsNext[lowBit] = (a < b);
				flagsNext[negativeBit] = ($signed(a) < $signed(b));
				flagsUpdate[lowBit] = 1'b1;
				flagsUpdate[negativeBit] = 1'b1;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluAnd:
			begin
				result = a & b;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluOr:
			begin
				result = a | b;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluXor:
			begin
				result = a ^ b;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluNot:
			begin
				// Inverts the destination operand
				result = ~a;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluLsh:
			begin
				result = a << shiftAmount;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluRsh:
			begin
				result = a >> shiftAmount;
				flagsUpdate[zeroBit] = 1'b1;
			end
			aluArsh:
			begin
				result = $signed(a) >>> shiftAmount;
				flagsUpdate[zeroBit] = 1'b1;
			end
			default:
			begin
				// Move passes b and leaves every flag alone
				result = b;
			end
		endcase

		// For compare the difference is zero exactly when a equals b
		flagsNext[zeroBit] = (result == '0);
	end

endmodule

//--- hw/aluDatapath.sv
`timescale 1ns/10ps

module aluDatapath
(
	input logic clk,
	input logic reset,
	input logic [isaPkg::instrWidth-1:0] instr,
	input logic req,
	output logic ack,
	output logic [datapathPkg::wordWidth-1:0] result,
	output logic [datapathPkg::psrWidth-1:0] psr
);
	import isaPkg::*;
	import datapathPkg::*;

	logic [instrWidth-1:0] latchedInstr;
	aluOpT aluOp;
	logic [regIndexWidth-1:0] destIndex;
	logic [regIndexWidth-1:0] srcIndex;
	logic useImmediate;
	logic writesResult;
	logic regWrite;
	logic [wordWidth-1:0] immediate;
	logic [wordWidth-1:0] readDataA;
	logic [wordWidth-1:0] readDataB;
	logic [wordWidth-1:0] operandB;
	logic [wordWidth-1:0] aluResult;
	logic [psrWidth-1:0] flagsNext;
	logic [psrWidth-1:0] flagsUpdate;

	////////////////////////////////////////////////////////////////////////////
	// Decode, operand read and execute
	////////////////////////////////////////////////////////////////////////////

	instructionDecoder i_decoder
	(
		.instr(latchedInstr),
		.aluOp(aluOp),
		.destIndex(destIndex),
		.srcIndex(srcIndex),
		.useImmediate(useImmediate),
		.immediate(immediate),
		.writesResult(writesResult)
	);

	// Destination register doubles as the first operand
	registerFile i_registerFile
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(regWrite),
		.writeIndex(destIndex),
		.writeData(aluResult),
		.readIndexA(destIndex),
		.readIndexB(srcIndex),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	assign operandB = useImmediate ? immediate : readDataB;

	alu i_alu
	(
		.a(readDataA),
		.b(operandB),
		.aluOp(aluOp),
		.carryIn(psr[carryBit]),
		.result(aluResult),
		.flagsNext(flagsNext),
		.flagsUpdate(flagsUpdate)
	);

	executeControl i_control
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.instr(instr),
		.aluResult(aluResult),
		.flagsNext(flagsNext),
		.flagsUpdate(flagsUpdate),
		.writesResult(writesResult),
		.ack(ack),
		.latchedInstr(latchedInstr),
		.regWrite(regWrite),
		.result(result),
		.psr(psr)
	);

endmodule

//--- hw/datapathPkg.sv
package datapathPkg;

	// Word and register file geometry
	localparam int wordWidth = 16;
	localparam int regIndexWidth = 4;

	// Processor status register
	localparam int psrWidth = 5;

	// Flag positions inside the PSR
	localparam int carryBit = 0;
	localparam int lowBit = 1;
	localparam int flagBit = 2;
	localparam int negativeBit = 3;
	localparam int zeroBit = 4;

endpackage

//--- hw/executeControl.sv
`timescale 1ns/10ps

module executeControl
(
	input logic clk,
	input logic reset,
	input logic req,
	input logic [isaPkg::instrWidth-1:0] instr,
	input logic [datapathPkg::wordWidth-1:0] aluResult,
	input logic [datapathPkg::psrWidth-1:0] flagsNext,
	input logic [datapathPkg::psrWidth-1:0] flagsUpdate,
	input logic writesResult,
	output logic ack,
	output logic [isaPkg::instrWidth-1:0] latchedInstr,
	output logic regWrite,
	output logic [datapathPkg::wordWidth-1:0] result,
	output logic [datapathPkg::psrWidth-1:0] psr
);

	typedef enum logic [1:0]
	{
		stateIdle,
		stateExecute,
		stateDone
	} stateT;

	stateT state;

	////////////////////////////////////////////////////////////////////////////
	// Instruction latch
	////////////////////////////////////////////////////////////////////////////

	// Captured on the edge that first sees req in Idle
	always_ff @(posedge clk)
	begin
		if (state == stateIdle && req)
		begin
			latchedInstr <= instr;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Handshake FSM and PSR
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			ack <= 1'b0;
			result <= '0;
			psr <= '0;
		end
		else
		begin
			case (state)
				stateIdle:
				begin
					if (req)
					begin
						state <= stateExecute;
					end
				end
				stateExecute:
				begin
					result <= aluResult;
					// Only the flags this operation defines are replaced
					psr <= (psr & ~flagsUpdate) | (flagsNext & flagsUpdate);
					ack <= 1'b1;
					state <= stateDone;
				end
				stateDone:
				begin
					// Host holds req to keep the result on display
					if (!req)
					begin
						ack <= 1'b0;
						state <= stateIdle;
					end
				end
				default:
				begin
					ack <= 1'b0;
					state <= stateIdle;
				end
			endcase
		end
	end

	// Write-back lands on the same edge as the PSR load
	assign regWrite = (state == stateExecute) && writesResult;

endmodule

//--- hw/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder
(
	input logic [isaPkg::instrWidth-1:0] instr,
	output isaPkg::aluOpT aluOp,
	output logic [datapathPkg::regIndexWidth-1:0] destIndex,
	output logic [datapathPkg::regIndexWidth-1:0] srcIndex,
	output logic useImmediate,
	output logic [datapathPkg::wordWidth-1:0] immediate,
	output logic writesResult
);
	import isaPkg::*;
	import datapathPkg::*;

	opcodeT opcode;
	extOpT extOp;
	logic [immWidth-1:0] immByte;
	logic [srcHi-srcLo:0] srcField;
	logic [wordWidth-1:0] signExtImm;
	logic [wordWidth-1:0] zeroExtImm;
	logic [wordWidth-1:0] shiftImm;

	// Field extraction
	assign opcode = opcodeT'(instr[opcodeHi:opcodeLo]);
	assign extOp = extOpT'(instr[extHi:extLo]);
	assign immByte = instr[immLo +: immWidth];
	assign srcField = instr[srcHi:srcLo];

	assign destIndex = instr[destHi:destLo];
	assign srcIndex = srcField;

	// Arithmetic immediates are signed, logic and move are not
	assign signExtImm = {{(wordWidth - immWidth){immByte[immWidth-1]}}, immByte};
	assign zeroExtImm = {{(wordWidth - immWidth){1'b0}}, immByte};
	assign shiftImm = {{(wordWidth - (srcHi - srcLo + 1)){1'b0}}, srcField};

	always_comb
	begin
		// Unknown codes fall through as a move that changes nothing
		aluOp = aluMov;
		useImmediate = 1'b0;
		immediate = zeroExtImm;
		writesResult = 1'b0;

		case (opcode)
			opRegister:
			begin
				writesResult = 1'b1;
				case (extOp)
					extAnd: aluOp = aluAnd;
					extOr: aluOp = aluOr;
					extXor: aluOp = aluXor;
					extNot: aluOp = aluNot;
					extAdd: aluOp = aluAdd;
					extAddu: aluOp = aluAddU;
					extAddc: aluOp = aluAddC;
					extSub: aluOp = aluSub;
					extCmp:
					begin
						aluOp = aluCmp;
						writesResult = 1'b0;
					end
					extMov: aluOp = aluMov;
					default: writesResult = 1'b0;
				endcase
			end
			opShift:
			begin
				writesResult = 1'b1;
				immediate = shiftImm;
				case (extOp)
					extLsh: aluOp = aluLsh;
					extRsh: aluOp = aluRsh;
					extArsh: aluOp = aluArsh;
					extLshi:
					begin
						aluOp = aluLsh;
						useImmediate = 1'b1;
					end
					extRshi:
					begin
						aluOp = aluRsh;
						useImmediate = 1'b1;
					end
					default: writesResult = 1'b0;
				endcase
			end
			opAndi, opOri, opXori, opMovi:
			begin
				useImmediate = 1'b1;
				writesResult = 1'b1;
				case (opcode)
					opAndi: aluOp = aluAnd;
					opOri: aluOp = aluOr;
					opXori: aluOp = aluXor;
					default: aluOp = aluMov;
				endcase
			end
			opAddi, opAddui, opAddci, opSubi, opCmpi:
			begin
				useImmediate = 1'b1;
				immediate = signExtImm;
				writesResult = (opcode != opCmpi);
				case (opcode)
					opAddi: aluOp = aluAdd;
					opAddui: aluOp = aluAddU;
					opAddci: aluOp = aluAddC;
					opSubi: aluOp = aluSub;
					default: aluOp = aluCmp;
				endcase
			end
			default:
			begin
				aluOp = aluMov;
			end
		endcase
	end

endmodule

//--- hw/isaPkg.sv
package isaPkg;

	// Instruction word and field positions
	localparam int instrWidth = 16;
	localparam int opcodeHi = 15;
	localparam int opcodeLo = 12;
	localparam int destHi = 11;
	localparam int destLo = 8;
	localparam int extHi = 7;
	localparam int extLo = 4;
	localparam int srcHi = 3;
	localparam int srcLo = 0;

	// Immediate forms take the low byte
	localparam int immLo = 0;
	localparam int immWidth = 8;

	// Major opcode in bits 15 to 12
	typedef enum logic [3:0]
	{
		opRegister = 4'h0,
		opAndi = 4'h1,
		opOri = 4'h2,
		opXori = 4'h3,
		opAddi = 4'h4,
		opAddui = 4'h5,
		opAddci = 4'h6,
		opShift = 4'h7,
		opSubi = 4'h8,
		opCmpi = 4'h9,
		opMovi = 4'ha
	} opcodeT;

	// Extended opcode for register and shift formats
	typedef enum logic [3:0]
	{
		extAnd = 4'h0,
		extOr = 4'h1,
		extXor = 4'h2,
		extNot = 4'h3,
		extAdd = 4'h4,
		extAddu = 4'h5,
		extAddc = 4'h6,
		extSub = 4'h7,
		extCmp = 4'h8,
		extMov = 4'h9,
		extLsh = 4'ha,
		extRsh = 4'hb,
		extArsh = 4'hc,
		extLshi = 4'hd,
		extRshi = 4'he
	} extOpT;

	typedef enum logic [3:0]
	{
		aluAdd,
		aluAddU,
		aluAddC,
		aluSub,
		aluCmp,
		aluAnd,
		aluOr,
		aluXor,
		aluNot,
		aluLsh,
		aluRsh,
		aluArsh,
		aluMov
	} aluOpT;

endpackage

//--- hw/registerFile.sv
`timescale 1ns/10ps

module registerFile
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input logic [datapathPkg::regIndexWidth-1:0] writeIndex,
	input logic [datapathPkg::wordWidth-1:0] writeData,
	input logic [datapathPkg::regIndexWidth-1:0] readIndexA,
	input logic [datapathPkg::regIndexWidth-1:0] readIndexB,
	output logic [datapathPkg::wordWidth-1:0] readDataA,
	output logic [datapathPkg::wordWidth-1:0] readDataB
);
	import datapathPkg::*;

	localparam int regCount = 1 << regIndexWidth;

	logic [wordWidth-1:0] regs [0:regCount-1];

	// Single write port
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEnable)
		begin
			regs[writeIndex] <= writeData;
		end
	end

	// Asynchronous reads see the old value during a write edge
	assign readDataA = regs[readIndexA];
	assign readDataB = regs[readIndexB];

endmodule

//--- list.f
+incdir+tb
hw/isaPkg.sv
hw/datapathPkg.sv
hw/instructionDecoder.sv
hw/alu.sv
hw/registerFile.sv
hw/executeControl.sv
hw/aluDatapath.sv
tb/aluDatapathTb.sv

//--- tb/aluDatapathTests.svh
////////////////////////////////////////////////////////////////////////////
// Instruction encoding and checks
////////////////////////////////////////////////////////////////////////////

function automatic logic [15:0] encodeReg(input extOpT ext, input logic [3:0] rd,
	input logic [3:0] rs);
	return {opRegister, rd, ext, rs};
endfunction

function automatic logic [15:0] encodeShift(input extOpT ext, input logic [3:0] rd,
	input logic [3:0] amount);
	return {opShift, rd, ext, amount};
endfunction

function automatic logic [15:0] encodeImm(input opcodeT op, input logic [3:0] rd,
	input logic [7:0] imm);
	return {op, rd, imm};
endfunction

task automatic checkValue(input string name, input logic [15:0] got,
	input logic [15:0] expected);
	checkCount++;
	assert (got === expected)
	else
	begin
		errorCount++;
		$display("Error at %0t: %s expected %h got %h", $time, name, expected, got);
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

task automatic predict
(
	input logic [15:0] word,
	output logic [15:0] expResult,
	output logic [4:0] expPsr,
	output logic resultKnown
);
	logic [3:0] op;
	logic [3:0] rd;
	logic [3:0] ext;
	logic [3:0] rs;
	logic [15:0] a;
	logic [15:0] b;
	logic [16:0] wide;
	logic [15:0] r;
	logic [4:0] p;
	logic writes;
	logic setsZero;
	aluOpT kind;

	op = word[15:12];
	rd = word[11:8];
	ext = word[7:4];
	rs = word[3:0];
	a = shadowRegs[rd];
	b = shadowRegs[rs];
	kind = aluMov;
	writes = 1'b1;

	case (op)
		opRegister:
		begin
			case (ext)
				extAnd: kind = aluAnd;
				extOr: kind = aluOr;
				extXor: kind = aluXor;
				extNot: kind = aluNot;
				extAdd: kind = aluAdd;
				extAddu: kind = aluAddU;
				extAddc: kind = aluAddC;
				extSub: kind = aluSub;
				extCmp:
				begin
					kind = aluCmp;
					writes = 1'b0;
				end
				extMov: kind = aluMov;
				default: writes = 1'b0;
			endcase
		end
		opShift:
		begin
			case (ext)
				extLsh: kind = aluLsh;
				extRsh: kind = aluRsh;
				extArsh: kind = aluArsh;
				extLshi:
				begin
					kind = aluLsh;
					b = {12'h000, rs};
				end
				extRshi:
				begin
					kind = aluRsh;
					b = {12'h000, rs};
				end
				default: writes = 1'b0;
			endcase
		end
		opAndi, opOri, opXori, opMovi:
		begin
			b = {8'h00, word[7:0]};
			case (op)
				opAndi: kind = aluAnd;
				opOri: kind = aluOr;
				opXori: kind = aluXor;
				default: kind = aluMov;
			endcase
		end
		opAddi, opAddui, opAddci, opSubi, opCmpi:
		begin
			b = {{8{word[7]}}, word[7:0]};
			writes = (op != opCmpi);
			case (op)
				opAddi: kind = aluAdd;
				opAddui: kind = aluAddU;
				opAddci: kind = aluAddC;
				opSubi: kind = aluSub;
				default: kind = aluCmp;
			endcase
		end
		default: writes = 1'b0;
	endcase

	p = shadowPsr;
	r = b;
	setsZero = 1'b1;
	case (kind)
		aluAdd:
		begin
			// Sign-extended sum overflows when its top two bits differ
			wide = {a[15], a} + {b[15], b};
			r = wide[15:0];
			p[flagBit] = (wide[16] != wide[15]);
		end
		aluAddU, aluAddC:
		begin
			wide = {1'b0, a} + {1'b0, b};
			if (kind == aluAddC)
			begin
				wide = wide + {16'h0000, shadowPsr[carryBit]};
			end
			r = wide[15:0];
			p[carryBit] = wide[16];
		end
		aluSub:
		begin
			wide = {a[15], a} - {b[15], b};
			r = wide[15:0];
			p[flagBit] = (wide[16] != wide[15]);
		end
		aluCmp:
		begin
			setsZero = 1'b0;
			p[lowBit] = (a < b);
			p[negativeBit] = ($signed(a) < $signed(b));
			p[zeroBit] = (a == b);
		end
		aluAnd: r = a & b;
		aluOr: r = a | b;
		aluXor: r = a ^ b;
		aluNot: r = ~a;
		aluLsh: r = a << b[3:0];
		aluRsh: r = a >> b[3:0];
		aluArsh: r = $signed(a) >>> b[3:0];
		default: setsZero = 1'b0;
	endcase

	if (setsZero)
	begin
		p[zeroBit] = (r == 16'h0000);
	end
	if (writes)
	begin
		shadowRegs[rd] = r;
	end
	shadowPsr = p;
	expResult = r;
	expPsr = p;
	resultKnown = writes;
endtask

////////////////////////////////////////////////////////////////////////////
// Handshake driver
////////////////////////////////////////////////////////////////////////////

task automatic issueHeld(input logic [15:0] word, input int holdCycles);
	logic [15:0] expResult;
	logic [4:0] expPsr;
	logic resultKnown;
	logic [15:0] heldResult;
	int waited;

	if (stalled)
	begin
		return;
	end
	predict(word, expResult, expPsr, resultKnown);

	@(negedge clk);
	instr = word;
	req = 1'b1;
	waited = 0;
	while (!ack && waited < ackTimeout)
	begin
		@(negedge clk);
		waited++;
	end
	if (!ack)
	begin
		stalled = 1'b1;
		timeoutCount++;
		$display("Timeout at %0t: ack never rose for instruction %h", $time, word);
		return;
	end

	// Ack two edges after req is first seen
	checkCount++;
	assert (waited == 2)
	else
	begin
		errorCount++;
		$display("Error at %0t: ack latency expected 2 got %0d", $time, waited);
	end
	if (resultKnown)
	begin
		checkValue("result", result, expResult);
	end
	checkValue("psr", psr, expPsr);

	heldResult = result;
	for (int i = 0; i < holdCycles; i++)
	begin
		@(negedge clk);
		checkValue("ack", ack, 16'h0001);
		checkValue("result", result, heldResult);
	end

	req = 1'b0;
	waited = 0;
	while (ack && waited < ackTimeout)
	begin
		@(negedge clk);
		waited++;
	end
	if (ack)
	begin
		stalled = 1'b1;
		timeoutCount++;
		$display("Timeout at %0t: ack stayed high after req fell", $time);
	end
endtask

task automatic issue(input logic [15:0] word);
	issueHeld(word, 0);
endtask

// Full word built from two immediates
task automatic loadWord(input logic [3:0] index, input logic [15:0] value);
	issue(encodeImm(opMovi, index, value[15:8]));
	issue(encodeShift(extLshi, index, 4'd8));
	issue(encodeImm(opOri, index, value[7:0]));
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic resetValues();
	checkValue("ack", ack, 16'h0000);
	checkValue("result", result, 16'h0000);
	checkValue("psr", psr, 16'h0000);
	issue(encodeReg(extMov, 4'd0, 4'd0));
endtask

task automatic signedArithmetic();
	logic [15:0] x;
	logic [15:0] y;

	// Carry and Low set up front so signed ops can leave them alone
	loadWord(4'd1, 16'hffff);
	issue(encodeImm(opAddui, 4'd1, 8'h01));
	issue(encodeImm(opCmpi, 4'd1, 8'h05));
	for (int i = 0; i < 6; i++)
	begin
		x = 16'($random(seed));
		y = 16'($random(seed));
		loadWord(4'd2, x);
		loadWord(4'd3, y);
		issue(encodeReg(extAdd, 4'd2, 4'd3));
		issue(encodeReg(extSub, 4'd2, 4'd3));
		issue(encodeImm(opAddi, 4'd3, 8'($random(seed))));
	end

	// Overflow corners
	loadWord(4'd4, 16'h7fff);
	loadWord(4'd5, 16'h0001);
	issue(encodeReg(extAdd, 4'd4, 4'd5));
	issue(encodeReg(extSub, 4'd4, 4'd5));
	loadWord(4'd6, 16'h8000);
	issue(encodeReg(extAdd, 4'd6, 4'd6));
	issue(encodeImm(opSubi, 4'd6, 8'h01));
	loadWord(4'd6, 16'h8000);
	issue(encodeImm(opSubi, 4'd6, 8'h01));
endtask

task automatic carryChains();
	loadWord(4'd3, 16'hffff);
	issue(encodeImm(opAddui, 4'd3, 8'h01));
	issue(encodeImm(opAddui, 4'd3, 8'hff));
	issue(encodeImm(opAddui, 4'd3, 8'h01));
	issue(encodeImm(opAddci, 4'd3, 8'h7f));

	// 32-bit sums from a low ADDU and a high ADDC
	for (int i = 0; i < 4; i++)
	begin
		loadWord(4'd4, 16'($random(seed)));
		loadWord(4'd5, 16'($random(seed)));
		loadWord(4'd6, 16'($random(seed)) | 16'h8000);
		loadWord(4'd7, 16'($random(seed)));
		issue(encodeReg(extAddu, 4'd4, 4'd6));
		issue(encodeReg(extAddc, 4'd5, 4'd7));
	end
endtask

task automatic compareCase(input logic [15:0] left, input logic [15:0] right);
	loadWord(4'd8, left);
	loadWord(4'd9, right);
	issue(encodeReg(extCmp, 4'd8, 4'd9));
	// Compare target must still hold its operand
	issue(encodeReg(extMov, 4'd10, 4'd8));
	checkValue("result", result, left);
endtask

task automatic compareFlags();
	compareCase(16'h1234, 16'h1234);
	compareCase(16'h0003, 16'h0009);
	compareCase(16'hfff0, 16'h0010);
	compareCase(16'h0010, 16'hfff0);
	compareCase(16'h8000, 16'h7fff);
	issue(encodeImm(opCmpi, 4'd8, 8'hf0));
	issue(encodeImm(opCmpi, 4'd8, 8'h7f));
	issue(encodeReg(extMov, 4'd11, 4'd8));
endtask

task automatic logicAndShifts();
	logic [15:0] x;
	logic [15:0] y;

	x = 16'($random(seed));
	y = 16'($random(seed));
	loadWord(4'd1, x);
	loadWord(4'd2, y);
	issue(encodeReg(extAnd, 4'd1, 4'd2));
	loadWord(4'd1, x);
	issue(encodeReg(extOr, 4'd1, 4'd2));
	issue(encodeReg(extXor, 4'd1, 4'd2));
	issue(encodeReg(extNot, 4'd1, 4'd0));
	issue(encodeReg(extXor, 4'd1, 4'd1));
	issue(encodeImm(opAndi, 4'd2, 8'h0f));
	issue(encodeImm(opXori, 4'd2, 8'ha5));

	loadWord(4'd3, 16'h9234);
	loadWord(4'd4, 16'h0005);
	issue(encodeReg(extLsh, 4'd3, 4'd4));
	loadWord(4'd3, 16'h9234);
	issue(encodeReg(extRsh, 4'd3, 4'd4));
	loadWord(4'd3, 16'h9234);
	issue(encodeReg(extArsh, 4'd3, 4'd4));
	issue(encodeShift(extLshi, 4'd3, 4'd3));
	issue(encodeShift(extRshi, 4'd3, 4'd15));
	issue(encodeShift(extRshi, 4'd3, 4'd1));

	// Unused opcode leaves registers and flags alone
	issue({4'hb, 4'h3, 8'h55});
	issue(encodeReg(extMov, 4'd12, 4'd3));
endtask

task automatic backPressure();
	loadWord(4'd1, 16'h1111);
	loadWord(4'd2, 16'h2222);
	issueHeld(encodeReg(extAdd, 4'd1, 4'd2), 20);
	issue(encodeReg(extSub, 4'd1, 4'd2));
endtask

//--- tb/aluDatapathTb.sv
`timescale 1ns/10ps

module aluDatapathTb;
	import isaPkg::*;
	import datapathPkg::*;

	// Edges allowed for each ack transition
	localparam int ackTimeout = 50;

	logic clk;
	logic reset;
	logic [15:0] instr;
	logic req;
	logic ack;
	logic [15:0] result;
	logic [4:0] psr;

	// Reference model state
	logic [15:0] shadowRegs [0:15];
	logic [4:0] shadowPsr;

	int errorCount;
	int timeoutCount;
	int checkCount;
	logic stalled;
	integer seed;

	aluDatapath i_dut
	(
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.req(req),
		.ack(ack),
		.result(result),
		.psr(psr)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	`include "aluDatapathTests.svh"

	initial
	begin
		reset = 1'b1;
		instr = '0;
		req = 1'b0;
		errorCount = 0;
		timeoutCount = 0;
		checkCount = 0;
		stalled = 1'b0;
		seed = 32'hd93e_d0a9;
		shadowPsr = '0;
		for (int i = 0; i < 16; i++)
		begin
			shadowRegs[i] = '0;
		end

		// Eight rising edges with reset held
		repeat (8) @(negedge clk);
		reset = 1'b0;

		resetValues();
		signedArithmetic();
		carryChains();
		compareFlags();
		logicAndShifts();
		backPressure();

		$display("Checks: %0d, errors: %0d, timeouts: %0d",
			checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
